// ==== cos_sim_pkg.sv ====
package cos_sim_pkg;

  ////////////////////////////////////////////////////////////
  // Data widths
  ////////////////////////////////////////////////////////////

  // One signed element of a vector
  localparam int ELEM_W    = 8;
  // Longest vector, marked by the last flag
  localparam int MAX_LEN   = 16;
  // Signed dot sum, 16 products of full range
  localparam int DOT_W     = 20;
  // Unsigned squared norm, 16 squares
  localparam int NORM_W    = 19;
  // Signed element product
  localparam int PROD_W    = 2 * ELEM_W;

  ////////////////////////////////////////////////////////////
  // Fixed point result and divider
  ////////////////////////////////////////////////////////////

  // Q1.14 result, range -16384 to +16384
  localparam int SIM_FRAC  = 14;
  localparam int SIM_W     = 16;
  // Quotient bits, enough for 2^SIM_FRAC
  localparam int DIV_STEPS = 15;
  localparam int CNT_W     = $clog2(DIV_STEPS);
  // Squared dot magnitude and shifted numerator
  localparam int SQ_W      = 2 * DOT_W;
  localparam int NUM_W     = SQ_W + SIM_FRAC;
  // Norm product and partial remainder
  localparam int DEN_W     = 2 * NORM_W;
  localparam int REM_W     = DEN_W + 1;

  ////////////////////////////////////////////////////////////
  // FSM encodings
  ////////////////////////////////////////////////////////////

  localparam logic IN_WAIT_REQ  = 1'b0;
  localparam logic IN_WAIT_DROP = 1'b1;

  localparam logic [2:0] CMB_IDLE    = 3'd0;
  localparam logic [2:0] CMB_SQUARE  = 3'd1;
  localparam logic [2:0] CMB_DIVIDE  = 3'd2;
  localparam logic [2:0] CMB_REQUEST = 3'd3;
  localparam logic [2:0] CMB_RELEASE = 3'd4;

endpackage

// ==== cos_elem_intake.sv ====
`timescale 1ns/1ps

module cos_elem_intake (
  input  logic                                    CLK,
  input  logic                                    RST,
  // Element pair handshake from the producer
  input  logic                                    elem_req,
  input  logic signed [cos_sim_pkg::ELEM_W-1:0]   elem_a,
  input  logic signed [cos_sim_pkg::ELEM_W-1:0]   elem_b,
  input  logic                                    elem_last,
  output logic                                    elem_ack,
  // Back-pressure from the combiner
  input  logic                                    combine_busy,
  // Broadcast to both accumulators
  output logic                                    acc_valid,
  output logic                                    acc_first,
  output logic signed [cos_sim_pkg::ELEM_W-1:0]   acc_a,
  output logic signed [cos_sim_pkg::ELEM_W-1:0]   acc_b,
  output logic                                    vec_done
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  logic in_state;
  // Next accepted pair opens a new vector
  logic first_pend;
  // Last flag of the pair now on acc_a/acc_b
  logic acc_last;
  logic take;

  ////////////////////////////////////////////////////////////
  // Acceptance
  ////////////////////////////////////////////////////////////

  // Last element waits until the combiner can capture again
  // vec_done covers the cycle before busy is registered
  assign take = elem_req & ~(elem_last & (combine_busy | vec_done));

  // Ack is the drop-wait state itself
  assign elem_ack = (in_state == cos_sim_pkg::IN_WAIT_DROP);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      in_state   <= cos_sim_pkg::IN_WAIT_REQ;
      first_pend <= 1'b1;
      acc_valid  <= 1'b0;
      acc_first  <= 1'b0;
      acc_last   <= 1'b0;
      vec_done   <= 1'b0;
    end else begin
      // Strobe by default
      acc_valid <= 1'b0;
      // One cycle after the accumulators took the last pair
      vec_done  <= acc_valid & acc_last;
      case (in_state)
        cos_sim_pkg::IN_WAIT_REQ: begin
          if (take) begin
            in_state   <= cos_sim_pkg::IN_WAIT_DROP;
            acc_valid  <= 1'b1;
            acc_first  <= first_pend;
            acc_last   <= elem_last;
            // A last element makes the following pair a first one
            first_pend <= elem_last;
          end
        end
        default: begin
          // Ack falls once req is seen low
          if (!elem_req) begin
            in_state <= cos_sim_pkg::IN_WAIT_REQ;
          end
        end
      endcase
    end
  end

  // Pair register, loaded on acceptance
  always_ff @(posedge CLK) begin
    if ((in_state == cos_sim_pkg::IN_WAIT_REQ) && take) begin
      acc_a <= elem_a;
      acc_b <= elem_b;
    end
  end

endmodule

// ==== cos_dot_accum.sv ====
`timescale 1ns/1ps

module cos_dot_accum (
  input  logic                                    CLK,
  input  logic                                    RST,
  input  logic                                    acc_valid,
  input  logic                                    acc_first,
  input  logic signed [cos_sim_pkg::ELEM_W-1:0]   acc_a,
  input  logic signed [cos_sim_pkg::ELEM_W-1:0]   acc_b,
  output logic signed [cos_sim_pkg::DOT_W-1:0]    dot_sum
);

  ////////////////////////////////////////////////////////////
  // Product
  ////////////////////////////////////////////////////////////

  logic signed [cos_sim_pkg::PROD_W-1:0] prod;
  logic signed [cos_sim_pkg::DOT_W-1:0]  prod_ext;

  // Signed 8x8 multiply
  assign prod = acc_a * acc_b;

  // Sign extension up to the sum width
  assign prod_ext = {{(cos_sim_pkg::DOT_W - cos_sim_pkg::PROD_W){prod[cos_sim_pkg::PROD_W-1]}},
                     prod};

  ////////////////////////////////////////////////////////////
  // Running sum
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      dot_sum <= '0;
    end else if (acc_valid) begin
      // First pair restarts, no leftover from the last vector
      if (acc_first) begin
        dot_sum <= prod_ext;
      end else begin
        dot_sum <= dot_sum + prod_ext;
      end
    end
  end

endmodule

// ==== cos_norm_accum.sv ====
`timescale 1ns/1ps

module cos_norm_accum (
  input  logic                                    CLK,
  input  logic                                    RST,
  input  logic                                    acc_valid,
  input  logic                                    acc_first,
  input  logic signed [cos_sim_pkg::ELEM_W-1:0]   acc_a,
  input  logic signed [cos_sim_pkg::ELEM_W-1:0]   acc_b,
  output logic        [cos_sim_pkg::NORM_W-1:0]   norm_a_sum,
  output logic        [cos_sim_pkg::NORM_W-1:0]   norm_b_sum
);

  ////////////////////////////////////////////////////////////
  // Squares
  ////////////////////////////////////////////////////////////

  logic signed [cos_sim_pkg::PROD_W-1:0] sq_a;
  logic signed [cos_sim_pkg::PROD_W-1:0] sq_b;
  logic        [cos_sim_pkg::NORM_W-1:0] sq_a_ext;
  logic        [cos_sim_pkg::NORM_W-1:0] sq_b_ext;

  // Never negative, at most 16384
  assign sq_a = acc_a * acc_a;
  assign sq_b = acc_b * acc_b;

  // Zero extension, sign bit is always clear
  assign sq_a_ext = {{(cos_sim_pkg::NORM_W - cos_sim_pkg::PROD_W){1'b0}}, sq_a};
  assign sq_b_ext = {{(cos_sim_pkg::NORM_W - cos_sim_pkg::PROD_W){1'b0}}, sq_b};

  ////////////////////////////////////////////////////////////
  // Twin sums
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      norm_a_sum <= '0;
      norm_b_sum <= '0;
    end else if (acc_valid) begin
      // Same first-load rule as the dot sum
      if (acc_first) begin
        norm_a_sum <= sq_a_ext;
        norm_b_sum <= sq_b_ext;
      end else begin
        norm_a_sum <= norm_a_sum + sq_a_ext;
        norm_b_sum <= norm_b_sum + sq_b_ext;
      end
    end
  end

endmodule

// ==== cos_sim_combine.sv ====
`timescale 1ns/1ps

module cos_sim_combine (
  input  logic                                    CLK,
  input  logic                                    RST,
  input  logic                                    vec_done,
  input  logic signed [cos_sim_pkg::DOT_W-1:0]    dot_sum,
  input  logic        [cos_sim_pkg::NORM_W-1:0]   norm_a_sum,
  input  logic        [cos_sim_pkg::NORM_W-1:0]   norm_b_sum,
  output logic                                    combine_busy,
  // Result handshake
  output logic                                    res_req,
  output logic signed [cos_sim_pkg::SIM_W-1:0]    res_sim,
  output logic                                    res_zero,
  input  logic                                    res_ack
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  logic [2:0]                            state;
  logic [cos_sim_pkg::CNT_W-1:0]         cnt;

  // Captured sums
  logic signed [cos_sim_pkg::DOT_W-1:0]  dot_q;
  logic [cos_sim_pkg::NORM_W-1:0]        na_q;
  logic [cos_sim_pkg::NORM_W-1:0]        nb_q;
  logic                                  neg_q;

  // Square stage
  logic [cos_sim_pkg::DOT_W-1:0]         mag;
  logic [cos_sim_pkg::SQ_W-1:0]          sq;
  logic [cos_sim_pkg::NUM_W-1:0]         num;
  logic [cos_sim_pkg::DEN_W-1:0]         den;

  // Divider state
  logic [cos_sim_pkg::REM_W-1:0]         rem;
  logic [cos_sim_pkg::DIV_STEPS-1:0]     low;
  logic [cos_sim_pkg::DEN_W-1:0]         den_q;
  logic [cos_sim_pkg::DIV_STEPS-1:0]     quo;
  logic                                  zero_q;

  // One divider step
  logic [cos_sim_pkg::REM_W-1:0]         shifted;
  logic                                  q_bit;
  logic [cos_sim_pkg::DIV_STEPS-1:0]     quo_next;
  logic [cos_sim_pkg::SIM_W-1:0]         q_ext;

  ////////////////////////////////////////////////////////////
  // Square and norm product
  ////////////////////////////////////////////////////////////

  // Magnitude of the dot sum, -2^19 still fits unsigned
  assign mag = neg_q ? (~dot_q + 1'b1) : dot_q;
  assign sq  = {{cos_sim_pkg::DOT_W{1'b0}}, mag} * {{cos_sim_pkg::DOT_W{1'b0}}, mag};
  // dot^2 scaled by 2^14
  assign num = {sq, {cos_sim_pkg::SIM_FRAC{1'b0}}};
  assign den = {{cos_sim_pkg::NORM_W{1'b0}}, na_q} * {{cos_sim_pkg::NORM_W{1'b0}}, nb_q};

  ////////////////////////////////////////////////////////////
  // Restoring divider step
  ////////////////////////////////////////////////////////////

  // Shift in the next numerator bit and try a subtract
  assign shifted  = {rem[cos_sim_pkg::REM_W-2:0], low[cos_sim_pkg::DIV_STEPS-1]};
  assign q_bit    = (shifted >= {1'b0, den_q});
  assign quo_next = {quo[cos_sim_pkg::DIV_STEPS-2:0], q_bit};
  assign q_ext    = {{(cos_sim_pkg::SIM_W - cos_sim_pkg::DIV_STEPS){1'b0}}, quo_next};

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= cos_sim_pkg::CMB_IDLE;
      cnt          <= '0;
      combine_busy <= 1'b0;
      res_req      <= 1'b0;
    end else begin
      case (state)
        cos_sim_pkg::CMB_IDLE: begin
          if (vec_done) begin
            state        <= cos_sim_pkg::CMB_SQUARE;
            combine_busy <= 1'b1;
          end
        end
        cos_sim_pkg::CMB_SQUARE: begin
          state <= cos_sim_pkg::CMB_DIVIDE;
          cnt   <= '0;
        end
        cos_sim_pkg::CMB_DIVIDE: begin
          // Fixed step count, zero norm included
          if (cnt == cos_sim_pkg::CNT_W'(cos_sim_pkg::DIV_STEPS - 1)) begin
            state   <= cos_sim_pkg::CMB_REQUEST;
            res_req <= 1'b1;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        cos_sim_pkg::CMB_REQUEST: begin
          if (res_ack) begin
            state   <= cos_sim_pkg::CMB_RELEASE;
            res_req <= 1'b0;
          end
        end
        cos_sim_pkg::CMB_RELEASE: begin
          // Handshake done once ack drops
          if (!res_ack) begin
            state        <= cos_sim_pkg::CMB_IDLE;
            combine_busy <= 1'b0;
          end
        end
        default: begin
          state <= cos_sim_pkg::CMB_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    case (state)
      cos_sim_pkg::CMB_IDLE: begin
        if (vec_done) begin
          dot_q <= dot_sum;
          na_q  <= norm_a_sum;
          nb_q  <= norm_b_sum;
          neg_q <= dot_sum[cos_sim_pkg::DOT_W-1];
        end
      end
      cos_sim_pkg::CMB_SQUARE: begin
        // Upper numerator part is below den, so 15 steps suffice
        rem    <= num[cos_sim_pkg::DIV_STEPS +: cos_sim_pkg::REM_W];
        low    <= num[cos_sim_pkg::DIV_STEPS-1:0];
        den_q  <= den;
        zero_q <= (den == '0);
        quo    <= '0;
      end
      cos_sim_pkg::CMB_DIVIDE: begin
        low <= {low[cos_sim_pkg::DIV_STEPS-2:0], 1'b0};
        quo <= quo_next;
        // Restore on a failed subtract
        if (q_bit && !zero_q) begin
          rem <= shifted - {1'b0, den_q};
        end else begin
          rem <= shifted;
        end
        // Last step, apply the sign or force zero
        if (cnt == cos_sim_pkg::CNT_W'(cos_sim_pkg::DIV_STEPS - 1)) begin
          res_zero <= zero_q;
          if (zero_q) begin
            res_sim <= '0;
          end else if (neg_q) begin
            res_sim <= -q_ext;
          end else begin
            res_sim <= q_ext;
          end
        end
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== cos_sim_top.sv ====
`timescale 1ns/1ps

module cos_sim_top (
  input  logic                                    CLK,
  input  logic                                    RST,
  // Element pairs in
  input  logic                                    elem_req,
  input  logic signed [cos_sim_pkg::ELEM_W-1:0]   elem_a,
  input  logic signed [cos_sim_pkg::ELEM_W-1:0]   elem_b,
  input  logic                                    elem_last,
  output logic                                    elem_ack,
  // Similarity out
  output logic                                    res_req,
  output logic signed [cos_sim_pkg::SIM_W-1:0]    res_sim,
  output logic                                    res_zero,
  input  logic                                    res_ack
);

  ////////////////////////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////////////////////////

  logic                                   acc_valid;
  logic                                   acc_first;
  logic signed [cos_sim_pkg::ELEM_W-1:0]  acc_a;
  logic signed [cos_sim_pkg::ELEM_W-1:0]  acc_b;
  logic                                   vec_done;
  logic                                   combine_busy;
  logic signed [cos_sim_pkg::DOT_W-1:0]   dot_sum;
  logic [cos_sim_pkg::NORM_W-1:0]         norm_a_sum;
  logic [cos_sim_pkg::NORM_W-1:0]         norm_b_sum;

  ////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////

  // Handshake and broadcast
  cos_elem_intake intake_i (
    .CLK(CLK), .RST(RST),
    .elem_req(elem_req), .elem_a(elem_a), .elem_b(elem_b),
    .elem_last(elem_last), .elem_ack(elem_ack),
    .combine_busy(combine_busy),
    .acc_valid(acc_valid), .acc_first(acc_first),
    .acc_a(acc_a), .acc_b(acc_b), .vec_done(vec_done)
  );

  // Dot product sum
  cos_dot_accum dot_i (
    .CLK(CLK), .RST(RST),
    .acc_valid(acc_valid), .acc_first(acc_first),
    .acc_a(acc_a), .acc_b(acc_b), .dot_sum(dot_sum)
  );

  // Squared norms, side by side with the dot sum
  cos_norm_accum norm_i (
    .CLK(CLK), .RST(RST),
    .acc_valid(acc_valid), .acc_first(acc_first),
    .acc_a(acc_a), .acc_b(acc_b),
    .norm_a_sum(norm_a_sum), .norm_b_sum(norm_b_sum)
  );

  // Square, divide and result handshake
  cos_sim_combine combine_i (
    .CLK(CLK), .RST(RST),
    .vec_done(vec_done), .dot_sum(dot_sum),
    .norm_a_sum(norm_a_sum), .norm_b_sum(norm_b_sum),
    .combine_busy(combine_busy),
    .res_req(res_req), .res_sim(res_sim), .res_zero(res_zero),
    .res_ack(res_ack)
  );

endmodule

// ==== tb_cos_assertions.sv ====
`timescale 1ns/1ps

module tb_cos_assertions (
  input logic                                  CLK,
  input logic                                  RST,
  input logic                                  elem_req,
  input logic                                  elem_ack,
  input logic                                  res_req,
  input logic signed [cos_sim_pkg::SIM_W-1:0]  res_sim,
  input logic                                  res_zero
);

  // Failures so far, read by the testbench top
  int fail_count = 0;

  ////////////////////////////////////////////////////////////
  // Handshake rules on the top ports
  ////////////////////////////////////////////////////////////

  // Ack only answers a request seen on the edge before
  ack_follows_req: assert property (
    @(posedge CLK) disable iff (RST)
    $rose(elem_ack) |-> $past(elem_req)
  ) else begin
    $error("elem_ack rose without a pending elem_req");
    fail_count++;
  end

  // Result word frozen for the whole request
  result_stable: assert property (
    @(posedge CLK) disable iff (RST)
    (res_req && $past(res_req)) |-> ($stable(res_sim) && $stable(res_zero))
  ) else begin
    $error("res_sim or res_zero changed while res_req was high");
    fail_count++;
  end

  // No request straight out of reset
  req_low_after_reset: assert property (
    @(posedge CLK)
    $past(RST) |-> !res_req
  ) else begin
    $error("res_req was high right after reset");
    fail_count++;
  end

endmodule

// Attached to every instance of the top level
bind cos_sim_top tb_cos_assertions asrt_i (
  .CLK(CLK),
  .RST(RST),
  .elem_req(elem_req),
  .elem_ack(elem_ack),
  .res_req(res_req),
  .res_sim(res_sim),
  .res_zero(res_zero)
);

// ==== tb_cos_checker.sv ====
`timescale 1ns/1ps

module tb_cos_checker (
  input  logic                                  CLK,
  input  logic                                  elem_ack,
  input  logic                                  elem_last,
  input  logic                                  res_req,
  input  logic signed [cos_sim_pkg::SIM_W-1:0]  res_sim,
  input  logic                                  res_zero,
  output int                                    fail_count
);

  // Last elem_ack rise to res_req rise, combiner idle
  localparam int LATENCY = 18;

  ////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////

  int exp_sim_q [$];
  bit exp_zero_q [$];
  // Cycle stamps of last-element acks
  int ack_cyc_q [$];

  int   cycle = 0;
  int   errors = 0;
  int   test_count = 0;
  int   pass_count = 0;
  logic ack_prev = 1'b0;
  logic req_prev = 1'b0;
  bit   lat_bad = 1'b0;
  bit   ok;
  int   lat;
  int   exp_sim;
  bit   exp_zero;
  logic signed [cos_sim_pkg::SIM_W-1:0] exp16;
  logic signed [cos_sim_pkg::SIM_W-1:0] got_sim;
  logic                                 got_zero;

  assign fail_count = errors;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // sign(dot) * floor(dot^2 * 2^14 / (na * nb)), zero norm gives 0
  function automatic int ref_sim(input int len, input int va [cos_sim_pkg::MAX_LEN],
                                 input int vb [cos_sim_pkg::MAX_LEN], output bit zero);
    longint dot;
    longint na;
    longint nb;
    longint q;
    int     i;
    dot = 0;
    na  = 0;
    nb  = 0;
    for (i = 0; i < len; i++) begin
      dot += longint'(va[i]) * longint'(vb[i]);
      na  += longint'(va[i]) * longint'(va[i]);
      nb  += longint'(vb[i]) * longint'(vb[i]);
    end
    if (na == 0 || nb == 0) begin
      zero = 1'b1;
      return 0;
    end
    zero = 1'b0;
    q = (dot * dot * (longint'(1) << cos_sim_pkg::SIM_FRAC)) / (na * nb);
    return int'((dot < 0) ? -q : q);
  endfunction

  // Called by the top for each vector it sends
  function automatic void push_vector(input int len, input int va [cos_sim_pkg::MAX_LEN],
                                      input int vb [cos_sim_pkg::MAX_LEN]);
    int e_sim;
    bit e_zero;
    e_sim = ref_sim(len, va, vb, e_zero);
    exp_sim_q.push_back(e_sim);
    exp_zero_q.push_back(e_zero);
  endfunction

  function automatic int outstanding();
    return exp_sim_q.size();
  endfunction

  function automatic void print_summary();
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             test_count, pass_count, test_count - pass_count, errors);
  endfunction

  ////////////////////////////////////////////////////////////
  // Monitor and compare, outputs sampled mid-cycle
  ////////////////////////////////////////////////////////////

  always @(negedge CLK) begin
    cycle++;
    // Data is held while ack is high, so elem_last is valid here
    if (elem_ack && !ack_prev && elem_last) begin
      ack_cyc_q.push_back(cycle);
    end
    if (res_req && !req_prev) begin
      if (ack_cyc_q.size() == 0) begin
        errors++;
        lat_bad = 1'b1;
        $display("res_req rose with no finished vector in flight");
      end else begin
        lat = cycle - ack_cyc_q.pop_front();
        if (lat != LATENCY) begin
          errors++;
          lat_bad = 1'b1;
          $display("Fail res_req latency: expected %0h, got %0h", LATENCY, lat);
        end
      end
    end
    if (res_req) begin
      got_sim  = res_sim;
      got_zero = res_zero;
    end
    // res_req falling closes one result handshake
    if (!res_req && req_prev) begin
      if (exp_sim_q.size() == 0) begin
        errors++;
        $display("A result arrived with no vector outstanding");
      end else begin
        exp_sim  = exp_sim_q.pop_front();
        exp_zero = exp_zero_q.pop_front();
        exp16    = exp_sim[cos_sim_pkg::SIM_W-1:0];
        ok       = !lat_bad;
        if (got_sim !== exp16) begin
          ok = 1'b0;
          errors++;
          $display("Fail res_sim: expected %h, got %h", exp16, got_sim);
        end
        if (got_zero !== exp_zero) begin
          ok = 1'b0;
          errors++;
          $display("Fail res_zero: expected %h, got %h", exp_zero, got_zero);
        end
        test_count++;
        if (ok) begin
          pass_count++;
        end
        $display("Test %0d: res_sim %h res_zero %b %s", test_count, got_sim, got_zero,
                 ok ? "ok" : "wrong");
      end
      lat_bad = 1'b0;
    end
    ack_prev = elem_ack;
    req_prev = res_req;
  end

endmodule

// ==== tb_cos_sim.sv ====
`timescale 1ns/1ps

module tb_cos_sim;

  ////////////////////////////////////////////////////////////
  // Limits and stimulus state
  ////////////////////////////////////////////////////////////

  // Cycles any single wait may take
  localparam int WAIT_LIMIT   = 300;
  localparam int RANDOM_COUNT = 40;
  // res_ack held off this long in the back-pressure test
  localparam int HOLD_CYCLES  = 90;

  logic                                  CLK;
  logic                                  RST;
  logic                                  elem_req;
  logic signed [cos_sim_pkg::ELEM_W-1:0] elem_a;
  logic signed [cos_sim_pkg::ELEM_W-1:0] elem_b;
  logic                                  elem_last;
  logic                                  elem_ack;
  logic                                  res_req;
  logic signed [cos_sim_pkg::SIM_W-1:0]  res_sim;
  logic                                  res_zero;
  logic                                  res_ack;

  int seed;
  bit timed_out;
  bit ack_hold;
  int fail_count;
  int va [cos_sim_pkg::MAX_LEN];
  int vb [cos_sim_pkg::MAX_LEN];

  ////////////////////////////////////////////////////////////
  // DUT and checker
  ////////////////////////////////////////////////////////////

  cos_sim_top dut_i (
    .CLK(CLK), .RST(RST),
    .elem_req(elem_req), .elem_a(elem_a), .elem_b(elem_b),
    .elem_last(elem_last), .elem_ack(elem_ack),
    .res_req(res_req), .res_sim(res_sim), .res_zero(res_zero),
    .res_ack(res_ack)
  );

  tb_cos_checker chk_i (
    .CLK(CLK), .elem_ack(elem_ack), .elem_last(elem_last),
    .res_req(res_req), .res_sim(res_sim), .res_zero(res_zero),
    .fail_count(fail_count)
  );

  // 10 ns period
  always #5 CLK = ~CLK;

  // Result side of the four-phase handshake
  initial begin
    res_ack = 1'b0;
    forever begin
      @(negedge CLK);
      if (res_req && !res_ack && !ack_hold) begin
        res_ack = 1'b1;
      end else if (!res_req && res_ack) begin
        res_ack = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic void flag_timeout(input string what);
    timed_out = 1'b1;
    $display("Timeout: %s within %0d cycles", what, WAIT_LIMIT);
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return lo + (r % (hi - lo + 1));
  endfunction

  function automatic void fill_random(input int len, input int lo, input int hi);
    int i;
    for (i = 0; i < len; i++) begin
      va[i] = rand_range(lo, hi);
      vb[i] = rand_range(lo, hi);
    end
  endfunction

  // One element pair changed only while req and ack are low
  task automatic send_pair(input int a, input int b, input bit last);
    int n;
    begin
      @(negedge CLK);
      n = 0;
      while (elem_ack && !timed_out) begin
        @(negedge CLK);
        n++;
        if (n > WAIT_LIMIT) flag_timeout("elem_ack did not fall");
      end
      if (!timed_out) begin
        elem_a    = 8'(a);
        elem_b    = 8'(b);
        elem_last = last;
        elem_req  = 1'b1;
        n = 0;
        while (!elem_ack && !timed_out) begin
          @(negedge CLK);
          n++;
          if (n > WAIT_LIMIT) flag_timeout("elem_ack did not rise");
        end
        elem_req = 1'b0;
      end
    end
  endtask

  // Expected value first, then the pairs
  task automatic run_vector(input int len);
    int i;
    begin
      if (!timed_out) begin
        chk_i.push_vector(len, va, vb);
        for (i = 0; i < len; i++) begin
          send_pair(va[i], vb[i], i == len - 1);
        end
      end
    end
  endtask

  task automatic wait_results();
    int n;
    begin
      n = 0;
      @(posedge CLK);
      while (chk_i.outstanding() != 0 && !timed_out) begin
        @(posedge CLK);
        n++;
        if (n > WAIT_LIMIT) flag_timeout("results still outstanding");
      end
      @(negedge CLK);
    end
  endtask

  task automatic pulse_reset();
    begin
      wait_results();
      repeat (4) @(negedge CLK);
      RST = 1'b1;
      repeat (3) @(negedge CLK);
      RST = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test groups
  ////////////////////////////////////////////////////////////

  // Identical gives +1.0, negated gives -1.0
  task automatic identical_and_negated(input int len);
    int i;
    begin
      fill_random(len, -127, 127);
      if (va[0] == 0) va[0] = 1;
      for (i = 0; i < len; i++) vb[i] = va[i];
      run_vector(len);
      for (i = 0; i < len; i++) vb[i] = -va[i];
      run_vector(len);
    end
  endtask

  // Orthogonal pair, then an all-zero vector
  task automatic orthogonal_and_zero();
    int i;
    begin
      va[0] = 3;
      va[1] = -2;
      va[2] = 7;
      va[3] = 1;
      vb[0] = 2;
      vb[1] = 3;
      vb[2] = 0;
      vb[3] = 0;
      run_vector(4);
      fill_random(6, 1, 127);
      for (i = 0; i < 6; i++) va[i] = 0;
      run_vector(6);
    end
  endtask

  task automatic random_vectors();
    int k;
    int len;
    begin
      for (k = 0; k < RANDOM_COUNT; k++) begin
        len = rand_range(1, cos_sim_pkg::MAX_LEN);
        fill_random(len, -128, 127);
        run_vector(len);
      end
    end
  endtask

  // Vectors keep coming while res_ack is held off
  task automatic held_result_ack();
    int k;
    begin
      wait_results();
      @(posedge CLK);
      ack_hold = 1'b1;
      fork
        begin
          for (k = 0; k < 4; k++) begin
            fill_random(cos_sim_pkg::MAX_LEN, -128, 127);
            run_vector(cos_sim_pkg::MAX_LEN);
          end
        end
        begin
          repeat (HOLD_CYCLES) @(negedge CLK);
          @(posedge CLK);
          ack_hold = 1'b0;
        end
      join
    end
  endtask

  // Single-element vectors and resets between vectors
  task automatic short_vectors_and_reset();
    int i;
    begin
      va[0] = 7;
      vb[0] = -3;
      run_vector(1);
      va[0] = 0;
      vb[0] = 5;
      run_vector(1);
      va[0] = -128;
      vb[0] = -128;
      run_vector(1);
      // Half a vector left in the sums, then reset
      wait_results();
      fill_random(5, 20, 127);
      for (i = 0; i < 5; i++) send_pair(va[i], vb[i], 1'b0);
      pulse_reset();
      fill_random(6, -128, 127);
      run_vector(6);
      pulse_reset();
      fill_random(1, -128, 127);
      run_vector(1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    CLK       = 1'b0;
    RST       = 1'b1;
    elem_req  = 1'b0;
    elem_a    = '0;
    elem_b    = '0;
    elem_last = 1'b0;
    ack_hold  = 1'b0;
    timed_out = 1'b0;
    seed      = 32'h78f8;
    repeat (3) @(negedge CLK);
    RST = 1'b0;

    identical_and_negated(cos_sim_pkg::MAX_LEN);
    identical_and_negated(5);
    orthogonal_and_zero();
    random_vectors();
    held_result_ack();
    short_vectors_and_reset();
    // Latency of every result is checked by the checker
    wait_results();

    chk_i.print_summary();
    if (!timed_out && fail_count == 0 && dut_i.asrt_i.fail_count == 0
        && chk_i.outstanding() == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
cos_sim_pkg.sv
cos_elem_intake.sv
cos_dot_accum.sv
cos_norm_accum.sv
cos_sim_combine.sv
cos_sim_top.sv
tb_cos_assertions.sv
tb_cos_checker.sv
tb_cos_sim.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the cosine similarity testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_cos_sim \
  -f flist.f \
  --Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

# Keep running after an assertion error so the testbench can report it
output=$(./obj_dir/Vtb_cos_sim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1
